//--- Bender.yml
package:
  name: eightbit_cpu

sources:
  - src/cpu_pkg.sv
  - src/fetch_unit.sv
  - src/decode_unit.sv
  - src/exec_unit.sv
  - src/writeback_unit.sv
  - src/mem_arbiter.sv
  - src/cpu_control.sv
  - src/eightbit_cpu.sv
  - target: test
    files:
      - tests/tb_eightbit_cpu.sv

//--- eightbit_cpu.f
src/cpu_pkg.sv
src/fetch_unit.sv
src/decode_unit.sv
src/exec_unit.sv
src/writeback_unit.sv
src/mem_arbiter.sv
src/cpu_control.sv
src/eightbit_cpu.sv
tests/tb_eightbit_cpu.sv

//--- src/cpu_control.sv
`timescale 1ns/1ns
`default_nettype none

module cpu_control #(
    parameter logic [7:0] reset_vector = 8'h00
) (
    input  logic              clk,
    input  logic              rst,
    input  logic              fetch_ready,
    input  logic              decode_ready,
    input  logic              exec_ready,
    input  logic              wb_ready,
    input  logic [7:0]        inst,
    input  cpu_pkg::decoded_t decoded,
    output logic              fetch_en,
    output logic              decode_en,
    output logic              exec_en,
    output logic              wb_en,
    output logic [7:0]        pc,
    output logic [7:0]        decode_inst,
    output cpu_pkg::decoded_t exec_cmd
);

    typedef enum logic [2:0] {
        s_fetch,
        s_decode,
        s_dispatch,
        s_execute,
        s_writeback
    } state_e;

    state_e state;
    logic   fetch_done;
    logic   decode_done;

    assign fetch_done  = (state == s_fetch) && fetch_en && fetch_ready;
    assign decode_done = (state == s_decode) && decode_ready;

    // one en is handed to the next on the same edge
    always_ff @(posedge clk) begin
        if (!rst) begin
            state     <= s_fetch;
            pc        <= reset_vector;
            fetch_en  <= 1'b0;
            decode_en <= 1'b0;
            exec_en   <= 1'b0;
            wb_en     <= 1'b0;
        end else begin
            case (state)
                s_fetch: begin
                    if (fetch_done) begin
                        fetch_en  <= 1'b0;
                        decode_en <= 1'b1;
                        pc        <= pc + 8'd1;
                        state     <= s_decode;
                    end else begin
                        fetch_en <= 1'b1;
                    end
                end
                s_decode: begin
                    if (decode_done) begin
                        decode_en <= 1'b0;
                        state     <= s_dispatch;
                    end
                end
                s_dispatch: begin
                    // jumps never reach execute
                    if (exec_cmd.op == cpu_pkg::op_jump) begin
                        pc       <= {2'b00, exec_cmd.target};
                        fetch_en <= 1'b1;
                        state    <= s_fetch;
                    end else begin
                        exec_en <= 1'b1;
                        state   <= s_execute;
                    end
                end
                s_execute: begin
                    if (exec_ready) begin
                        exec_en <= 1'b0;
                        wb_en   <= 1'b1;
                        state   <= s_writeback;
                    end
                end
                s_writeback: begin
                    if (wb_ready) begin
                        wb_en    <= 1'b0;
                        fetch_en <= 1'b1;
                        state    <= s_fetch;
                    end
                end
                default: state <= s_fetch;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (fetch_done) begin
            decode_inst <= inst;
        end
        if (decode_done) begin
            exec_cmd <= decoded;
        end
    end

    single_stage: assert property (@(posedge clk) disable iff (!rst)
        $onehot0({fetch_en, decode_en, exec_en, wb_en}));

endmodule

`default_nettype wire

//--- src/cpu_pkg.sv
`default_nettype none

package cpu_pkg;

    typedef enum logic [1:0] {
        op_jump  = 2'b00,
        op_load  = 2'b01,
        op_store = 2'b10,
        op_add   = 2'b11
    } opcode_e;

    // instruction byte as it comes off the bus
    typedef struct packed {
        opcode_e    op;
        logic       sel_a;
        logic [4:0] addr;
    } inst_t;

    typedef struct packed {
        opcode_e    op;
        logic       sel_a;
        logic [5:0] target;
    } decoded_t;

    typedef struct packed {
        logic       valid;
        logic       we;
        logic [7:0] addr;
        logic [7:0] wdata;
    } mem_req_t;

    typedef struct packed {
        logic       valid;
        logic       sel_a;
        logic [7:0] value;
    } wb_t;

    // load and store offsets are added to this
    localparam logic [7:0] data_base = 8'hE0;

endpackage

`default_nettype wire

//--- src/decode_unit.sv
`timescale 1ns/1ns
`default_nettype none

module decode_unit (
    input  logic              clk,
    input  logic              rst,
    input  logic              en,
    input  logic [7:0]        inst,
    output cpu_pkg::decoded_t decoded,
    output logic              ready
);

    cpu_pkg::inst_t fields;

    assign fields = cpu_pkg::inst_t'(inst);

    always_ff @(posedge clk) begin
        if (!rst) begin
            ready <= 1'b0;
        end else begin
            ready <= en;
        end
    end

    // jump target borrows the select bit as its msb
    always_ff @(posedge clk) begin
        if (en && !ready) begin
            decoded.op     <= fields.op;
            decoded.sel_a  <= fields.sel_a;
            decoded.target <= {fields.sel_a, fields.addr};
        end
    end

endmodule

`default_nettype wire

//--- src/eightbit_cpu.sv
`timescale 1ns/1ns
`default_nettype none

module eightbit_cpu #(
    parameter logic [7:0] reset_vector = 8'h00
) (
    input  logic              clk,
    input  logic              rst,
    input  logic              mem_ready,
    input  logic [7:0]        rdata,
    output cpu_pkg::mem_req_t bus_req
);

    logic              fetch_en;
    logic              fetch_ready;
    logic              decode_en;
    logic              decode_ready;
    logic              exec_en;
    logic              exec_ready;
    logic              wb_en;
    logic              wb_ready;
    logic [7:0]        pc;
    logic [7:0]        fetch_inst;
    logic [7:0]        decode_inst;
    logic [7:0]        reg_a;
    logic [7:0]        reg_b;
    cpu_pkg::decoded_t decoded;
    cpu_pkg::decoded_t exec_cmd;
    cpu_pkg::mem_req_t fetch_req;
    cpu_pkg::mem_req_t exec_req;
    cpu_pkg::wb_t      exec_result;
    logic              fetch_mem_ready;
    logic              exec_mem_ready;

    cpu_control #(
        .reset_vector(reset_vector)
    ) u_control (
        .clk         (clk),
        .rst         (rst),
        .fetch_ready (fetch_ready),
        .decode_ready(decode_ready),
        .exec_ready  (exec_ready),
        .wb_ready    (wb_ready),
        .inst        (fetch_inst),
        .decoded     (decoded),
        .fetch_en    (fetch_en),
        .decode_en   (decode_en),
        .exec_en     (exec_en),
        .wb_en       (wb_en),
        .pc          (pc),
        .decode_inst (decode_inst),
        .exec_cmd    (exec_cmd)
    );

    fetch_unit u_fetch (
        .clk      (clk),
        .rst      (rst),
        .en       (fetch_en),
        .pc       (pc),
        .mem_ready(fetch_mem_ready),
        .rdata    (rdata),
        .req      (fetch_req),
        .inst     (fetch_inst),
        .ready    (fetch_ready)
    );

    decode_unit u_decode (
        .clk    (clk),
        .rst    (rst),
        .en     (decode_en),
        .inst   (decode_inst),
        .decoded(decoded),
        .ready  (decode_ready)
    );

    exec_unit u_exec (
        .clk      (clk),
        .rst      (rst),
        .en       (exec_en),
        .cmd      (exec_cmd),
        .a        (reg_a),
        .b        (reg_b),
        .mem_ready(exec_mem_ready),
        .rdata    (rdata),
        .req      (exec_req),
        .result   (exec_result),
        .ready    (exec_ready)
    );

    writeback_unit u_writeback (
        .clk   (clk),
        .rst   (rst),
        .en    (wb_en),
        .result(exec_result),
        .a     (reg_a),
        .b     (reg_b),
        .ready (wb_ready)
    );

    mem_arbiter u_arbiter (
        .clk        (clk),
        .rst        (rst),
        .fetch_req  (fetch_req),
        .exec_req   (exec_req),
        .mem_ready  (mem_ready),
        .fetch_ready(fetch_mem_ready),
        .exec_ready (exec_mem_ready),
        .bus_req    (bus_req)
    );

endmodule

`default_nettype wire

//--- src/exec_unit.sv
`timescale 1ns/1ns
`default_nettype none

module exec_unit (
    input  logic              clk,
    input  logic              rst,
    input  logic              en,
    input  cpu_pkg::decoded_t cmd,
    input  logic [7:0]        a,
    input  logic [7:0]        b,
    input  logic              mem_ready,
    input  logic [7:0]        rdata,
    output cpu_pkg::mem_req_t req,
    output cpu_pkg::wb_t      result,
    output logic              ready
);

    logic       is_mem;
    logic       is_add;
    logic [7:0] sel_val;

    assign is_mem  = (cmd.op == cpu_pkg::op_load) || (cmd.op == cpu_pkg::op_store);
    assign is_add  = (cmd.op == cpu_pkg::op_add);
    assign sel_val = cmd.sel_a ? a : b;

    assign req.valid = en && !ready && is_mem;
    assign req.we    = (cmd.op == cpu_pkg::op_store);
    assign req.addr  = cpu_pkg::data_base + {3'b000, cmd.target[4:0]};
    assign req.wdata = sel_val;

    always_ff @(posedge clk) begin
        if (!rst) begin
            ready <= 1'b0;
        end else if (!en) begin
            ready <= 1'b0;
        end else if (!ready) begin
            // add needs one cycle, memory ops wait for the strobe
            if (is_add || (is_mem && mem_ready)) begin
                ready <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (en && !ready) begin
            if (is_add) begin
                result.valid <= 1'b1;
                result.sel_a <= cmd.sel_a;
                result.value <= a + b;
            end else if (is_mem && mem_ready) begin
                // a store leaves the registers alone
                result.valid <= (cmd.op == cpu_pkg::op_load);
                result.sel_a <= cmd.sel_a;
                result.value <= req.we ? sel_val : rdata;
            end
        end
    end

    req_held: assert property (@(posedge clk) disable iff (!rst)
        req.valid && !mem_ready |=> req.valid && $stable(req));

endmodule

`default_nettype wire

//--- src/fetch_unit.sv
`timescale 1ns/1ns
`default_nettype none

module fetch_unit (
    input  logic              clk,
    input  logic              rst,
    input  logic              en,
    input  logic [7:0]        pc,
    input  logic              mem_ready,
    input  logic [7:0]        rdata,
    output cpu_pkg::mem_req_t req,
    output logic [7:0]        inst,
    output logic              ready
);

    // read request stays up until the byte has been captured
    assign req.valid = en && !ready;
    assign req.we    = 1'b0;
    assign req.addr  = pc;
    assign req.wdata = 8'h00;

    always_ff @(posedge clk) begin
        if (!rst) begin
            ready <= 1'b0;
        end else if (!en) begin
            ready <= 1'b0;
        end else if (mem_ready) begin
            ready <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (en && mem_ready) begin
            inst <= rdata;
        end
    end

endmodule

`default_nettype wire

//--- src/mem_arbiter.sv
`timescale 1ns/1ns
`default_nettype none

module mem_arbiter (
    input  logic              clk,
    input  logic              rst,
    input  cpu_pkg::mem_req_t fetch_req,
    input  cpu_pkg::mem_req_t exec_req,
    input  logic              mem_ready,
    output logic              fetch_ready,
    output logic              exec_ready,
    output cpu_pkg::mem_req_t bus_req
);

    logic gnt_fetch;
    logic gnt_exec;

    // strobe goes back only to the unit that owns the bus
    assign fetch_ready = mem_ready && gnt_fetch;
    assign exec_ready  = mem_ready && gnt_exec;

    always_ff @(posedge clk) begin
        if (!rst) begin
            gnt_fetch     <= 1'b0;
            gnt_exec      <= 1'b0;
            bus_req.valid <= 1'b0;
            bus_req.we    <= 1'b0;
        end else if (gnt_fetch || gnt_exec) begin
            // grant is never preempted and ends with the strobe
            if (mem_ready) begin
                gnt_fetch     <= 1'b0;
                gnt_exec      <= 1'b0;
                bus_req.valid <= 1'b0;
                bus_req.we    <= 1'b0;
            end
        end else if (exec_req.valid) begin
            gnt_exec <= 1'b1;
            bus_req  <= exec_req;
        end else if (fetch_req.valid) begin
            gnt_fetch <= 1'b1;
            bus_req   <= fetch_req;
        end
    end

    one_owner: assert property (@(posedge clk) disable iff (!rst)
        !(fetch_ready && exec_ready));

    // memory may only answer a request that is on the bus
    strobe_on_request: assert property (@(posedge clk) disable iff (!rst)
        mem_ready |-> bus_req.valid);

endmodule

`default_nettype wire

//--- src/writeback_unit.sv
`timescale 1ns/1ns
`default_nettype none

module writeback_unit (
    input  logic         clk,
    input  logic         rst,
    input  logic         en,
    input  cpu_pkg::wb_t result,
    output logic [7:0]   a,
    output logic [7:0]   b,
    output logic         ready
);

    always_ff @(posedge clk) begin
        if (!rst) begin
            a     <= 8'h00;
            b     <= 8'h00;
            ready <= 1'b0;
        end else begin
            ready <= en;
            // write once, on the first cycle of en
            if (en && !ready && result.valid) begin
                if (result.sel_a) begin
                    a <= result.value;
                end else begin
                    b <= result.value;
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- tests/tb_eightbit_cpu.sv
`timescale 1ns/1ns
`default_nettype none

module tb_eightbit_cpu;

    localparam logic [7:0] reset_vector = 8'h30;
    localparam int reset_cycles = 10;
    localparam int max_lat = 4;
    // worst bus access as the core sees it, memory latency plus arbiter and strobe cycles
    localparam int access_cycles = max_lat + 2;
    localparam int n_directed = 5;
    localparam int n_random = 200;
    localparam int n_inst = n_directed + n_random;
    localparam int timeout_cycles = n_inst * 4 * access_cycles + reset_cycles;
    localparam logic [7:0] val_a = 8'hC8;
    localparam logic [7:0] val_b = 8'h7B;

    typedef struct packed {
        logic [7:0] pc;
        logic [7:0] a;
        logic [7:0] b;
    } ref_state_t;

    logic              clk;
    logic              rst;
    logic              mem_ready;
    logic [7:0]        rdata;
    cpu_pkg::mem_req_t bus_req;

    logic [7:0]        mem [0:255];
    logic [7:0]        ref_mem [0:255];
    cpu_pkg::mem_req_t got_q [$];
    cpu_pkg::mem_req_t exp_q [$];
    integer            seed;
    logic              busy;
    int                wait_cnt;
    logic [7:0]        read_val;

    eightbit_cpu #(
        .reset_vector(reset_vector)
    ) dut (
        .clk      (clk),
        .rst      (rst),
        .mem_ready(mem_ready),
        .rdata    (rdata),
        .bus_req  (bus_req)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    task automatic abort_run;
        $display("test failed");
        $fatal(1, "simulation stopped on error");
    endtask

    task automatic check_req(input cpu_pkg::mem_req_t exp, input cpu_pkg::mem_req_t got,
                             input int idx);
        if (got.we !== exp.we) begin
            $display("FAIL bus_req.we (request %0d): expected 0x%h, got 0x%h", idx, exp.we, got.we);
            abort_run();
        end else if (got.addr !== exp.addr) begin
            $display("FAIL bus_req.addr (request %0d): expected 0x%h, got 0x%h",
                     idx, exp.addr, got.addr);
            abort_run();
        end else if (exp.we && got.wdata !== exp.wdata) begin
            $display("FAIL bus_req.wdata (request %0d): expected 0x%h, got 0x%h",
                     idx, exp.wdata, got.wdata);
            abort_run();
        end
    endtask

    task automatic check_byte(input logic [7:0] addr, input logic [7:0] exp);
        if (mem[addr] !== exp) begin
            $display("FAIL mem[0x%h]: expected 0x%h, got 0x%h", addr, exp, mem[addr]);
            abort_run();
        end
    endtask

    // one instruction of the architecture, returns 1 when a data access follows the fetch
    function automatic logic cpu_step(inout ref_state_t st,
                                      output cpu_pkg::mem_req_t fetch_rd,
                                      output cpu_pkg::mem_req_t data_acc);
        logic [7:0] inst;
        logic [7:0] addr;
        logic [7:0] sel_val;
        logic [7:0] sum;
        inst = ref_mem[st.pc];
        fetch_rd = '0;
        fetch_rd.valid = 1'b1;
        fetch_rd.addr = st.pc;
        data_acc = '0;
        st.pc = st.pc + 8'd1;
        addr = cpu_pkg::data_base + {3'b000, inst[4:0]};
        sel_val = inst[5] ? st.a : st.b;
        case (cpu_pkg::opcode_e'(inst[7:6]))
            cpu_pkg::op_jump: begin
                st.pc = {2'b00, inst[5:0]};
                return 1'b0;
            end
            cpu_pkg::op_load: begin
                data_acc.valid = 1'b1;
                data_acc.addr = addr;
                if (inst[5]) begin
                    st.a = ref_mem[addr];
                end else begin
                    st.b = ref_mem[addr];
                end
                return 1'b1;
            end
            cpu_pkg::op_store: begin
                data_acc.valid = 1'b1;
                data_acc.we = 1'b1;
                data_acc.addr = addr;
                data_acc.wdata = sel_val;
                ref_mem[addr] = sel_val;
                return 1'b1;
            end
            default: begin
                sum = st.a + st.b;
                if (inst[5]) begin
                    st.a = sum;
                end else begin
                    st.b = sum;
                end
                return 1'b0;
            end
        endcase
    endfunction

    // memory model, writes land when the request is accepted
    always @(posedge clk) begin
        if (!rst) begin
            mem_ready <= 1'b0;
            busy = 1'b0;
        end else if (mem_ready) begin
            // bus_req still shows the finished request on this edge
            mem_ready <= 1'b0;
        end else if (busy) begin
            if (wait_cnt == 0) begin
                mem_ready <= 1'b1;
                rdata     <= read_val;
                busy = 1'b0;
            end else begin
                wait_cnt = wait_cnt - 1;
            end
        end else if (bus_req.valid) begin
            busy = 1'b1;
            wait_cnt = $unsigned($random(seed)) % max_lat;
            got_q.push_back(bus_req);
            if (bus_req.we) begin
                mem[bus_req.addr] = bus_req.wdata;
            end
            read_val = mem[bus_req.addr];
        end
    end

    initial begin
        repeat (timeout_cycles) @(posedge clk);
        $display("timeout: core did not complete %0d instructions within %0d cycles",
                 n_inst, timeout_cycles);
        abort_run();
    end

    initial begin
        int                i;
        int                directed_reqs;
        logic              found;
        logic [7:0]        addr_b;
        logic [7:0]        byte_v;
        logic [8:0]        wide_sum;
        logic              has_data;
        ref_state_t        st;
        cpu_pkg::mem_req_t f_req;
        cpu_pkg::mem_req_t d_req;
        cpu_pkg::mem_req_t got;

        seed = 43740;
        rst = 1'b0;
        mem_ready = 1'b0;
        rdata = 8'h00;
        for (i = 0; i < 256; i++) begin
            addr_b = i;
            mem[i] = addr_b * 8'd7 + 8'h03;
        end
        // random program at 0x00, its jumps stay below 0x2f
        for (i = 0; i < 8'h2F; i++) begin
            byte_v = $random(seed);
            if (byte_v[7:6] == 2'b00) begin
                byte_v[5:0] = byte_v[5:0] % 6'd47;
            end
            mem[i] = byte_v;
        end
        mem[8'h2F] = 8'h00;
        for (i = 8'hE0; i < 256; i++) begin
            mem[i] = $random(seed);
        end
        mem[8'hE1] = val_a;
        mem[8'hE2] = val_b;
        // load a, load b, add into a, store a to 0xe5, jump to 0x00
        mem[reset_vector]        = 8'h61;
        mem[reset_vector + 8'd1] = 8'h42;
        mem[reset_vector + 8'd2] = 8'hE0;
        mem[reset_vector + 8'd3] = 8'hA5;
        mem[reset_vector + 8'd4] = 8'h00;
        wide_sum = {1'b0, val_a} + {1'b0, val_b};

        for (i = 0; i < 256; i++) begin
            ref_mem[i] = mem[i];
        end
        st = '0;
        st.pc = reset_vector;
        directed_reqs = 0;
        for (i = 0; i < n_inst; i++) begin
            has_data = cpu_step(st, f_req, d_req);
            exp_q.push_back(f_req);
            if (has_data) begin
                exp_q.push_back(d_req);
            end
            if (i == n_directed - 1) begin
                directed_reqs = exp_q.size();
            end
        end

        repeat (reset_cycles) begin
            @(negedge clk);
            if (bus_req.valid !== 1'b0 || bus_req.we !== 1'b0) begin
                $display("FAIL bus_req.valid/we in reset: expected 0x0/0x0, got 0x%h/0x%h",
                         bus_req.valid, bus_req.we);
                abort_run();
            end
        end
        @(posedge clk);
        rst <= 1'b1;

        found = 1'b0;
        repeat (3) begin
            @(negedge clk);
            if (bus_req.valid === 1'b1) begin
                found = 1'b1;
            end
        end
        if (!found) begin
            $display("first fetch request did not show up within 3 cycles of reset release");
            abort_run();
        end

        for (i = 0; i < exp_q.size(); i++) begin
            wait (got_q.size() > 0);
            got = got_q.pop_front();
            check_req(exp_q[i], got, i);
            if (i + 1 == directed_reqs) begin
                check_byte(8'hE5, wide_sum[7:0]);
            end
        end

        for (i = 8'hE0; i < 256; i++) begin
            check_byte(i, ref_mem[i]);
        end
        $display("test passed");
        $finish;
    end

endmodule

`default_nettype wire
